// File: src/ram_settings.svh
// geometry macros for the banked word memory
// word width, address width, bank size and count, scan length width
`ifndef RAM_SETTINGS_SVH
`define RAM_SETTINGS_SVH

// data word, four bytes
`define RAM_DATA_WIDTH 32

// word address, 1024 words in total
`define RAM_ADDR_WIDTH 10

// words in one bank
`define RAM_BANK_WORDS 256

// banks needed to cover the address space
`define RAM_NUM_BANKS ((1 << `RAM_ADDR_WIDTH) / `RAM_BANK_WORDS)

`define RAM_BANK_BITS 2      // upper address bits, bank index

`define RAM_SCAN_LEN_WIDTH 10 // scan length, zero reads 1024 words

`endif

// File: src/ram_types_pkg.sv
// data, address, mask and length types for the memory and scan port
`include "ram_settings.svh"

package ram_types_pkg;

  // one memory word
  typedef logic [`RAM_DATA_WIDTH-1:0] word_t;

  // full word address, bank index on top
  typedef logic [`RAM_ADDR_WIDTH-1:0] addr_t;

  typedef logic [$clog2(`RAM_BANK_WORDS)-1:0] offs_t; // word within a bank

  typedef logic [`RAM_BANK_BITS-1:0] bank_t; // selects one bank

  // one enable per byte lane
  typedef logic [`RAM_DATA_WIDTH/8-1:0] wmask_t;

  // words per scan, 0 is the full 1024
  typedef logic [`RAM_SCAN_LEN_WIDTH-1:0] scan_len_t;

endpackage

// File: src/ram_ctrl_pkg.sv
// host opcode and scan FSM state encodings

package ram_ctrl_pkg;

  // host port command, sampled every cycle
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0, // idle cycle
    OP_WRITE = 2'd1, // masked write at the edge
    OP_READ  = 2'd2  // word returned one cycle later
  } host_op_e;

  // scan reader FSM
  typedef enum logic [1:0] {
    SCAN_IDLE  = 2'd0, // waiting for start
    SCAN_RUN   = 2'd1, // one read per cycle
    SCAN_DRAIN = 2'd2  // last word comes back
  } scan_state_e;

endpackage

// File: src/sram_bank_256.sv
// one 256-word bank, byte-masked write on port 0
// registered reads on port 0 and port 1
`timescale 1ns/100ps
`include "ram_settings.svh"

module sram_bank_256 (
  input  logic                  clk1,
  input  ram_types_pkg::wmask_t we,    // byte enables, port 0 only
  input  logic                  en0,
  input  ram_types_pkg::offs_t  addr0,
  input  ram_types_pkg::word_t  din0,
  output ram_types_pkg::word_t  dout0,
  input  logic                  en1,
  input  ram_types_pkg::offs_t  addr1,
  output ram_types_pkg::word_t  dout1
);

  // storage, contents undefined until written
  ram_types_pkg::word_t mem [`RAM_BANK_WORDS];

  // port 0
  // writes go lane by lane under the mask
  // a read is an enabled cycle with no byte enables
  always_ff @(posedge clk1) begin
    if (en0) begin
      for (int b = 0; b < $bits(ram_types_pkg::wmask_t); b++) begin
        if (we[b]) begin
          mem[addr0][b*8 +: 8] <= din0[b*8 +: 8]; // one byte lane
        end
      end
      if (we == '0) begin
        dout0 <= mem[addr0]; // holds across writes
      end
    end
  end

  // port 1, read only
  // same-cycle write to addr1 is not seen, old word comes out
  always_ff @(posedge clk1) begin
    if (en1) begin
      dout1 <= mem[addr1];
    end
  end

  // no stray byte enables outside a port 0 access
  a_we_needs_en0 : assert property (
    @(posedge clk1) (|we) |-> en0
  ) else $error("bank write enables without en0");

endmodule

// File: src/dffram_wrapper.sv
// banked 1024-word memory built from 256-word banks
// host opcode decode, per-bank enables, registered bank select on both ports
`timescale 1ns/100ps
`include "ram_settings.svh"

module dffram_wrapper (
  input  logic                   clk1,
  input  logic                   arst_n,
  input  ram_ctrl_pkg::host_op_e op0,
  input  ram_types_pkg::wmask_t  wmask0,
  input  ram_types_pkg::addr_t   addr0,
  input  ram_types_pkg::word_t   din0,
  output ram_types_pkg::word_t   dout0,
  output logic                   rvalid0,
  input  logic                   en1,
  input  ram_types_pkg::addr_t   addr1,
  output ram_types_pkg::word_t   dout1
);

  logic                      rd0;      // host read this cycle
  logic                      wr0;      // host write with some byte set
  ram_types_pkg::bank_t      bank0;    // upper bits of host address
  ram_types_pkg::bank_t      bank1;    // upper bits of scan address
  ram_types_pkg::offs_t      offs0;
  ram_types_pkg::offs_t      offs1;
  ram_types_pkg::bank_t      bank0_q;  // bank of last host read
  ram_types_pkg::bank_t      bank1_q;  // bank of last scan read
  logic [`RAM_NUM_BANKS-1:0] bank_en0;
  logic [`RAM_NUM_BANKS-1:0] bank_en1;
  ram_types_pkg::word_t      dout0_w [`RAM_NUM_BANKS];
  ram_types_pkg::word_t      dout1_w [`RAM_NUM_BANKS];

  // opcode decode
  // empty-mask write does nothing, keeps the read register quiet
  assign rd0 = (op0 == ram_ctrl_pkg::OP_READ);
  assign wr0 = (op0 == ram_ctrl_pkg::OP_WRITE) && (|wmask0);

  // address split, bank on top, offset below
  assign bank0 = addr0[`RAM_ADDR_WIDTH-1 -: `RAM_BANK_BITS];
  assign bank1 = addr1[`RAM_ADDR_WIDTH-1 -: `RAM_BANK_BITS];
  assign offs0 = addr0[`RAM_ADDR_WIDTH-`RAM_BANK_BITS-1:0];
  assign offs1 = addr1[`RAM_ADDR_WIDTH-`RAM_BANK_BITS-1:0];

  for (genvar i = 0; i < `RAM_NUM_BANKS; i++) begin : g_bank
    ram_types_pkg::wmask_t we_b;  // mask only reaches the hit bank

    assign bank_en0[i] = (rd0 || wr0) && (bank0 == ram_types_pkg::bank_t'(i));
    assign bank_en1[i] = en1 && (bank1 == ram_types_pkg::bank_t'(i));
    assign we_b        = (bank_en0[i] && wr0) ? wmask0 : '0;

    sram_bank_256 u_bank (
      .clk1  (clk1),
      .we    (we_b),
      .en0   (bank_en0[i]),
      .addr0 (offs0),
      .din0  (din0),
      .dout0 (dout0_w[i]),
      .en1   (bank_en1[i]),
      .addr1 (offs1),
      .dout1 (dout1_w[i])
    );
  end

  // bank index follows the read into the next cycle
  // only moves on a read so the output word holds otherwise
  always_ff @(posedge clk1 or negedge arst_n) begin
    if (!arst_n) begin
      bank0_q <= '0;
      bank1_q <= '0;
      rvalid0 <= 1'b0;
    end else begin
      rvalid0 <= rd0;            // one pulse per host read
      if (rd0) begin
        bank0_q <= bank0;
      end
      if (en1) begin
        bank1_q <= bank1;
      end
    end
  end

  assign dout0 = dout0_w[bank0_q]; // read mux, host
  assign dout1 = dout1_w[bank1_q]; // read mux, scan

  // address decode never hits two banks on one port
  a_one_bank : assert property (
    @(posedge clk1) disable iff (!arst_n)
    $onehot0(bank_en0) && $onehot0(bank_en1)
  ) else $error("more than one bank enabled on a port");

endmodule

// File: src/scan_reader.sv
// burst read controller for port 1
// issues consecutive reads and tags each returned word with its index
`timescale 1ns/100ps

module scan_reader (
  input  logic                    clk1,
  input  logic                    arst_n,
  input  logic                    start,    // one-cycle pulse
  input  ram_types_pkg::addr_t    base,
  input  ram_types_pkg::scan_len_t len,     // 0 reads all 1024 words
  output logic                    rd_en,
  output ram_types_pkg::addr_t    rd_addr,
  input  ram_types_pkg::word_t    rd_data,  // one cycle after rd_en
  output ram_types_pkg::word_t    data,
  output logic                    valid,
  output ram_types_pkg::scan_len_t index,
  output logic                    done,
  output logic                    busy
);

  ram_ctrl_pkg::scan_state_e state;
  ram_types_pkg::addr_t      addr_q;    // address of next read
  ram_types_pkg::scan_len_t  remain_q;  // reads still to issue
  ram_types_pkg::scan_len_t  idx_q;     // index of read being issued
  ram_types_pkg::scan_len_t  idx_d1;    // lines up with rd_data
  logic                      rd_en_d1;
  logic                      accept;
  logic                      last_issue;

  // busy drops with done so a new scan may start during drain
  assign busy       = (state == ram_ctrl_pkg::SCAN_RUN);
  assign accept     = start && !busy;
  assign rd_en      = (state == ram_ctrl_pkg::SCAN_RUN);
  assign rd_addr    = addr_q;
  assign last_issue = rd_en && (remain_q == ram_types_pkg::scan_len_t'(1)); // 0 wraps to 1023

  always_ff @(posedge clk1 or negedge arst_n) begin
    if (!arst_n) begin
      state <= ram_ctrl_pkg::SCAN_IDLE;
    end else begin
      case (state)
        ram_ctrl_pkg::SCAN_RUN: begin
          if (last_issue) begin
            state <= ram_ctrl_pkg::SCAN_DRAIN;
          end
        end
        // idle and drain both take a start
        ram_ctrl_pkg::SCAN_IDLE, ram_ctrl_pkg::SCAN_DRAIN: begin
          state <= start ? ram_ctrl_pkg::SCAN_RUN : ram_ctrl_pkg::SCAN_IDLE;
        end
        default: state <= ram_ctrl_pkg::SCAN_IDLE;
      endcase
    end
  end

  // address, remaining and index counters
  always_ff @(posedge clk1 or negedge arst_n) begin
    if (!arst_n) begin
      addr_q   <= '0;
      remain_q <= '0;
      idx_q    <= '0;
      rd_en_d1 <= 1'b0;
      idx_d1   <= '0;
    end else begin
      if (accept) begin
        addr_q   <= base;
        remain_q <= len;
        idx_q    <= '0;
      end else if (rd_en) begin
        addr_q   <= addr_q + 1'b1;   // wraps mod 1024
        remain_q <= remain_q - 1'b1;
        idx_q    <= idx_q + 1'b1;
      end
      rd_en_d1 <= rd_en;             // read data is one cycle behind
      idx_d1   <= idx_q;
    end
  end

  assign data  = rd_data;
  assign valid = rd_en_d1;
  assign index = idx_d1;
  assign done  = (state == ram_ctrl_pkg::SCAN_DRAIN); // last word is on data now

  a_no_start_busy : assert property (
    @(posedge clk1) disable iff (!arst_n) busy |-> !start
  ) else $error("scan start while busy, ignored");

  // done only follows the final read of the count
  a_done_with_last : assert property (
    @(posedge clk1) disable iff (!arst_n) done |-> valid && $past(last_issue)
  ) else $error("scan done without its last word");

endmodule

// File: src/ram_scan_top.sv
// top level, banked memory with host port and burst scan reader
`timescale 1ns/100ps

module ram_scan_top (
  input  logic                     clk1,
  input  logic                     arst_n,
  input  ram_ctrl_pkg::host_op_e   host_op,
  input  ram_types_pkg::addr_t     host_addr,
  input  ram_types_pkg::wmask_t    host_wmask,
  input  ram_types_pkg::word_t     host_wdata,
  output ram_types_pkg::word_t     host_rdata,
  output logic                     host_rvalid,
  input  logic                     scan_start,
  input  ram_types_pkg::addr_t     scan_base,
  input  ram_types_pkg::scan_len_t scan_len,
  output ram_types_pkg::word_t     scan_data,
  output logic                     scan_valid,
  output ram_types_pkg::scan_len_t scan_index,
  output logic                     scan_done,
  output logic                     scan_busy
);

  logic                 rd1_en;    // scan read strobe
  ram_types_pkg::addr_t rd1_addr;
  ram_types_pkg::word_t rd1_data;  // registered in the banks

  dffram_wrapper u_ram (
    .clk1    (clk1),
    .arst_n  (arst_n),
    .op0     (host_op),
    .wmask0  (host_wmask),
    .addr0   (host_addr),
    .din0    (host_wdata),
    .dout0   (host_rdata),
    .rvalid0 (host_rvalid),
    .en1     (rd1_en),
    .addr1   (rd1_addr),
    .dout1   (rd1_data)
  );

  scan_reader u_scan (
    .clk1    (clk1),
    .arst_n  (arst_n),
    .start   (scan_start),
    .base    (scan_base),
    .len     (scan_len),
    .rd_en   (rd1_en),
    .rd_addr (rd1_addr),
    .rd_data (rd1_data),
    .data    (scan_data),
    .valid   (scan_valid),
    .index   (scan_index),
    .done    (scan_done),
    .busy    (scan_busy)
  );

endmodule

// File: verif/tb_vectors.svh
// stimulus table, host accesses, fills and scans, loaded into the testbench queues
// columns: name, kind, opcode, address, byte mask, data, length
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic load_vectors();
  // flags stay low through idle cycles
  add_vec("reset_nop", KIND_IDLE, NOP, 10'd0, 4'h0, 32'h0, 10'd8);
  // edges of every bank, each read one cycle after its write
  add_vec("bank_w255", KIND_HOST, WR, 10'd255, 4'hf, 32'h0bad_00ff, 10'd0);
  add_vec("bank_r255", KIND_HOST, RD, 10'd255, 4'h0, 32'h0, 10'd0);
  add_vec("bank_w256", KIND_HOST, WR, 10'd256, 4'hf, 32'h1bad_0100, 10'd0);
  add_vec("bank_r256", KIND_HOST, RD, 10'd256, 4'h0, 32'h0, 10'd0);
  add_vec("bank_w1023", KIND_HOST, WR, 10'd1023, 4'hf, 32'h3bad_03ff, 10'd0);
  add_vec("bank_r1023", KIND_HOST, RD, 10'd1023, 4'h0, 32'h0, 10'd0);
  add_vec("bank_w0", KIND_HOST, WR, 10'd0, 4'hf, 32'h0bad_0000, 10'd0);
  add_vec("bank_w600", KIND_HOST, WR, 10'd600, 4'hf, 32'h2bad_0258, 10'd0);
  add_vec("bank_r0", KIND_HOST, RD, 10'd0, 4'h0, 32'h0, 10'd0);
  add_vec("bank_r600", KIND_HOST, RD, 10'd600, 4'h0, 32'h0, 10'd0);
  add_vec("bank_r255_again", KIND_HOST, RD, 10'd255, 4'h0, 32'h0, 10'd0);
  add_vec("bank_gap", KIND_IDLE, NOP, 10'd0, 4'h0, 32'h0, 10'd3); // rdata holds
  // byte lanes over a known word
  add_vec("mask_full", KIND_HOST, WR, 10'd300, 4'hf, 32'h1122_3344, 10'd0);
  add_vec("mask_0001", KIND_HOST, WR, 10'd300, 4'h1, 32'haabb_ccdd, 10'd0);
  add_vec("mask_0001_rd", KIND_HOST, RD, 10'd300, 4'h0, 32'h0, 10'd0); // 112233dd
  add_vec("mask_0110", KIND_HOST, WR, 10'd300, 4'h6, 32'h5566_7788, 10'd0);
  add_vec("mask_0110_rd", KIND_HOST, RD, 10'd300, 4'h0, 32'h0, 10'd0); // 116677dd
  add_vec("mask_1000", KIND_HOST, WR, 10'd300, 4'h8, 32'h9900_0000, 10'd0);
  add_vec("mask_1000_rd", KIND_HOST, RD, 10'd300, 4'h0, 32'h0, 10'd0); // 996677dd
  // scan across the 255/256 bank edge
  add_vec("fill_250", KIND_FILL, NOP, 10'd250, 4'h0, 32'h0, 10'd12);
  add_vec("scan_250", KIND_SCAN, NOP, 10'd250, 4'h0, 32'h0, 10'd12);
  add_vec("scan_250_wait", KIND_WAIT, NOP, 10'd0, 4'h0, 32'h0, 10'd0);
  // scan wrapping past 1023 to 0
  add_vec("fill_1020", KIND_FILL, NOP, 10'd1020, 4'h0, 32'h0, 10'd8);
  add_vec("scan_1020", KIND_SCAN, NOP, 10'd1020, 4'h0, 32'h0, 10'd8);
  add_vec("scan_1020_wait", KIND_WAIT, NOP, 10'd0, 4'h0, 32'h0, 10'd0);
  // host traffic during a scan, start driven at edge d
  add_vec("fill_600", KIND_FILL, NOP, 10'd600, 4'h0, 32'h0, 10'd10);
  add_vec("scan_600", KIND_SCAN, NOP, 10'd600, 4'h0, 32'h0, 10'd10);
  add_vec("mix_w605", KIND_HOST, WR, 10'd605, 4'hf, 32'hcafe_0005, 10'd0); // ahead
  add_vec("mix_r601", KIND_HOST, RD, 10'd601, 4'h0, 32'h0, 10'd0);
  add_vec("mix_nop", KIND_IDLE, NOP, 10'd0, 4'h0, 32'h0, 10'd1);
  add_vec("mix_w603", KIND_HOST, WR, 10'd603, 4'hf, 32'hdead_0003, 10'd0); // scan gets old
  add_vec("mix_r603", KIND_HOST, RD, 10'd603, 4'h0, 32'h0, 10'd0);         // host gets new
  add_vec("mix_w608", KIND_HOST, WR, 10'd608, 4'h3, 32'h0000_beef, 10'd0); // low half only
  add_vec("scan_600_wait", KIND_WAIT, NOP, 10'd0, 4'h0, 32'h0, 10'd0);
  add_vec("post_r603", KIND_HOST, RD, 10'd603, 4'h0, 32'h0, 10'd0);
  add_vec("post_r608", KIND_HOST, RD, 10'd608, 4'h0, 32'h0, 10'd0);
endtask

`endif

// File: verif/tb_ram_scan.sv
// testbench for ram_scan_top with clock, reset and a reference memory model
// table-driven host and scan stimulus, cycle-exact compare tasks, timed waits
`timescale 1ns/100ps
`include "ram_settings.svh"

module tb_ram_scan;

  localparam int KIND_HOST  = 0;    // one host cycle
  localparam int KIND_FILL  = 1;    // len random full-word writes from addr
  localparam int KIND_SCAN  = 2;    // start pulse, base in addr
  localparam int KIND_WAIT  = 3;    // NOP cycles until scan_done
  localparam int KIND_IDLE  = 4;    // len NOP cycles
  localparam int WAIT_LIMIT = 2000; // cycles per wait loop
  localparam int MEM_WORDS  = 1 << `RAM_ADDR_WIDTH;
  localparam ram_ctrl_pkg::host_op_e NOP = ram_ctrl_pkg::OP_NOP;
  localparam ram_ctrl_pkg::host_op_e WR  = ram_ctrl_pkg::OP_WRITE;
  localparam ram_ctrl_pkg::host_op_e RD  = ram_ctrl_pkg::OP_READ;

  logic                     clk1;
  logic                     arst_n;
  ram_ctrl_pkg::host_op_e   host_op;
  ram_types_pkg::addr_t     host_addr;
  ram_types_pkg::wmask_t    host_wmask;
  ram_types_pkg::word_t     host_wdata;
  ram_types_pkg::word_t     host_rdata;
  logic                     host_rvalid;
  logic                     scan_start;
  ram_types_pkg::addr_t     scan_base;
  ram_types_pkg::scan_len_t scan_len;
  ram_types_pkg::word_t     scan_data;
  logic                     scan_valid;
  ram_types_pkg::scan_len_t scan_index;
  logic                     scan_done;
  logic                     scan_busy;

  ram_types_pkg::word_t model [MEM_WORDS]; // mirrors every masked write
  integer               seed;              // fill data
  int                   cyc;               // rising edges since reset release
  string                cur_name;          // entry being applied
  ram_types_pkg::word_t last_rdata;        // host_rdata must hold this
  logic                 rdata_known;

  // stimulus table, filled by load_vectors
  string                    vec_name [$];
  int                       vec_kind [$];
  ram_ctrl_pkg::host_op_e   vec_op [$];
  ram_types_pkg::addr_t     vec_addr [$];
  ram_types_pkg::wmask_t    vec_mask [$];
  ram_types_pkg::word_t     vec_data [$];
  ram_types_pkg::scan_len_t vec_len [$];

  // pending host reads, keyed by the cycle they show up
  int                   host_exp_cyc [$];
  ram_types_pkg::word_t host_exp_data [$];
  string                host_exp_name [$];

  // pending scan words
  int                       scan_exp_cyc [$];
  ram_types_pkg::scan_len_t scan_exp_idx [$];
  ram_types_pkg::word_t     scan_exp_word [$];
  logic                     scan_exp_last [$];

  // scan being issued
  string                scan_name;
  int                   scan_start_cyc; // edge that drove the start pulse
  int                   scan_total;     // zero length means 1024
  int                   scan_issued;
  ram_types_pkg::addr_t scan_base_r;
  int                   busy_from;      // busy window in cycles
  int                   busy_to;

  ram_scan_top i_dut (
    .clk1        (clk1),
    .arst_n      (arst_n),
    .host_op     (host_op),
    .host_addr   (host_addr),
    .host_wmask  (host_wmask),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .scan_start  (scan_start),
    .scan_base   (scan_base),
    .scan_len    (scan_len),
    .scan_data   (scan_data),
    .scan_valid  (scan_valid),
    .scan_index  (scan_index),
    .scan_done   (scan_done),
    .scan_busy   (scan_busy)
  );

  initial begin
    clk1 = 1'b0;
    forever #2 clk1 = ~clk1; // 4 ns period
  end

  task automatic check_word(input string name, input ram_types_pkg::word_t exp_w,
                            input ram_types_pkg::word_t act_w);
    if (act_w !== exp_w) begin
      $display("Fail %s: expected %h, actual %h", name, exp_w, act_w);
      $display("Test failures found");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_index(input string name, input ram_types_pkg::scan_len_t exp_i,
                             input ram_types_pkg::scan_len_t act_i);
    if (act_i !== exp_i) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp_i, act_i);
      $display("Test failures found");
      $fatal(1, "index mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_f, input logic act_f);
    if (act_f !== exp_f) begin
      $display("Fail %s: expected %b, actual %b", name, exp_f, act_f);
      $display("Test failures found");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic add_vec(input string name, input int kind, input ram_ctrl_pkg::host_op_e op,
                         input ram_types_pkg::addr_t addr, input ram_types_pkg::wmask_t mask,
                         input ram_types_pkg::word_t data, input ram_types_pkg::scan_len_t len);
    vec_name.push_back(name);
    vec_kind.push_back(kind);
    vec_op.push_back(op);
    vec_addr.push_back(addr);
    vec_mask.push_back(mask);
    vec_data.push_back(data);
    vec_len.push_back(len);
  endtask

  `include "tb_vectors.svh"

  // enabled byte lanes take the new word
  function automatic ram_types_pkg::word_t merge_bytes(input ram_types_pkg::word_t old_w,
                                                       input ram_types_pkg::word_t new_w,
                                                       input ram_types_pkg::wmask_t mask);
    ram_types_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < $bits(mask); b++) begin
      if (mask[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // read k goes out after edge start+1+k, sees writes driven up to start+k
  task automatic capture_scan();
    int k;
    if (scan_issued < scan_total && cyc == scan_start_cyc + 1 + scan_issued) begin
      k = scan_issued;
      scan_exp_cyc.push_back(cyc + 1);
      scan_exp_idx.push_back(ram_types_pkg::scan_len_t'(k));
      scan_exp_word.push_back(model[(int'(scan_base_r) + k) % MEM_WORDS]); // wraps
      scan_exp_last.push_back(k == scan_total - 1);
      scan_issued++;
    end
  endtask

  task automatic check_outputs();
    logic busy_exp;
    busy_exp = (cyc >= busy_from) && (cyc <= busy_to);
    if (host_exp_cyc.size() > 0 && host_exp_cyc[0] == cyc) begin
      check_flag({host_exp_name[0], " host_rvalid"}, 1'b1, host_rvalid);
      check_word({host_exp_name[0], " host_rdata"}, host_exp_data[0], host_rdata);
      last_rdata  = host_exp_data[0];
      rdata_known = 1'b1;
      void'(host_exp_cyc.pop_front());
      void'(host_exp_data.pop_front());
      void'(host_exp_name.pop_front());
    end else begin
      check_flag({cur_name, " host_rvalid"}, 1'b0, host_rvalid);
      if (rdata_known) begin
        check_word({cur_name, " host_rdata hold"}, last_rdata, host_rdata);
      end
    end
    if (scan_exp_cyc.size() > 0 && scan_exp_cyc[0] == cyc) begin
      check_flag({scan_name, " scan_valid"}, 1'b1, scan_valid);
      check_index({scan_name, " scan_index"}, scan_exp_idx[0], scan_index);
      check_word({scan_name, " scan_data"}, scan_exp_word[0], scan_data);
      check_flag({scan_name, " scan_done"}, scan_exp_last[0], scan_done);
      void'(scan_exp_cyc.pop_front());
      void'(scan_exp_idx.pop_front());
      void'(scan_exp_word.pop_front());
      void'(scan_exp_last.pop_front());
    end else begin
      check_flag({cur_name, " scan_valid"}, 1'b0, scan_valid);
      check_flag({cur_name, " scan_done"}, 1'b0, scan_done);
    end
    check_flag({cur_name, " scan_busy"}, busy_exp, scan_busy);
  endtask

  // one clock: drive at the rising edge, check at the falling edge
  task automatic step(input ram_ctrl_pkg::host_op_e op, input ram_types_pkg::addr_t a,
                      input ram_types_pkg::wmask_t m, input ram_types_pkg::word_t d,
                      input logic st, input ram_types_pkg::scan_len_t sl);
    @(posedge clk1);
    cyc++;
    capture_scan(); // before this edge's write
    if (op == WR) begin
      model[a] = merge_bytes(model[a], d, m);
    end
    if (op == RD) begin
      host_exp_cyc.push_back(cyc + 1);
      host_exp_data.push_back(model[a]);
      host_exp_name.push_back(cur_name);
    end
    if (st) begin
      scan_name      = cur_name;
      scan_start_cyc = cyc;
      scan_base_r    = a;
      scan_total     = (sl == '0) ? MEM_WORDS : int'(sl);
      scan_issued    = 0;
      busy_from      = cyc + 1;
      busy_to        = cyc + scan_total;
    end
    host_op    <= op;
    host_addr  <= a;
    host_wmask <= m;
    host_wdata <= d;
    scan_start <= st;
    scan_base  <= a;
    scan_len   <= sl;
    @(negedge clk1);
    check_outputs();
  endtask

  task automatic fill_words(input ram_types_pkg::addr_t a, input ram_types_pkg::scan_len_t n);
    ram_types_pkg::word_t w;
    for (int k = 0; k < int'(n); k++) begin
      w = $random(seed);
      step(WR, ram_types_pkg::addr_t'((int'(a) + k) % MEM_WORDS), 4'hf, w, 1'b0, '0);
    end
  endtask

  task automatic wait_scan_done();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      step(NOP, '0, '0, '0, 1'b0, '0);
      seen = scan_done;
      n++;
      if (!seen && n >= WAIT_LIMIT) begin
        $display("timed out waiting for scan_done in %s", cur_name);
        $display("Test failures found");
        $fatal(1, "scan wait timed out");
      end
    end
  endtask

  // drains outstanding host reads
  task automatic wait_host_rvalid();
    int n;
    n = 0;
    while (host_exp_cyc.size() > 0) begin
      step(NOP, '0, '0, '0, 1'b0, '0);
      n++;
      if (host_exp_cyc.size() > 0 && n >= WAIT_LIMIT) begin
        $display("timed out waiting for host_rvalid in %s", cur_name);
        $display("Test failures found");
        $fatal(1, "host read wait timed out");
      end
    end
  endtask

  initial begin
    seed        = 64597;
    cyc         = 0;
    busy_from   = 1;
    busy_to     = 0;   // empty window
    scan_total  = 0;
    scan_issued = 0;
    rdata_known = 1'b0;
    cur_name    = "reset";
    scan_name   = "none";
    arst_n      <= 1'b0;
    host_op     <= NOP;
    host_addr   <= '0;
    host_wmask  <= '0;
    host_wdata  <= '0;
    scan_start  <= 1'b0;
    scan_base   <= '0;
    scan_len    <= '0;
    repeat (15) @(posedge clk1);
    @(negedge clk1);
    check_flag("reset host_rvalid", 1'b0, host_rvalid);
    check_flag("reset scan_valid", 1'b0, scan_valid);
    check_flag("reset scan_done", 1'b0, scan_done);
    check_flag("reset scan_busy", 1'b0, scan_busy);
    @(posedge clk1);
    arst_n <= 1'b1; // 16th edge
    load_vectors();
    for (int i = 0; i < vec_name.size(); i++) begin
      cur_name = vec_name[i];
      case (vec_kind[i])
        KIND_HOST: step(vec_op[i], vec_addr[i], vec_mask[i], vec_data[i], 1'b0, '0);
        KIND_FILL: fill_words(vec_addr[i], vec_len[i]);
        KIND_SCAN: step(NOP, vec_addr[i], '0, '0, 1'b1, vec_len[i]);
        KIND_WAIT: wait_scan_done();
        default:   repeat (vec_len[i]) step(NOP, '0, '0, '0, 1'b0, '0);
      endcase
    end
    cur_name = "final";
    wait_host_rvalid();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: all.f
+incdir+src
+incdir+verif
src/ram_types_pkg.sv
src/ram_ctrl_pkg.sv
src/sram_bank_256.sv
src/dffram_wrapper.sv
src/scan_reader.sv
src/ram_scan_top.sv
verif/tb_ram_scan.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ram_scan -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_ram_scan 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q -F "All tests passed!"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
